// ==== hw/spriteMotion_cfg.svh ====
// coordinate, gain and timer widths
// object count and start corners of each object
`ifndef SPRITE_MOTION_CFG_SVH
`define SPRITE_MOTION_CFG_SVH

// display coordinate magnitude without the sign bit
`define COORD_W       11
`define NUM_OBJ       2

// signed gain settings with one extra bit each
`define BASIC_GAIN_W  3
`define DASH_GAIN_W   4
`define JUMP_VEL_W    4
`define JUMP_PER_W    6	// frames per speed step up to 63

// both start boxes lie on screen
`define OBJ0_X        64
`define OBJ0_Y        416
`define OBJ1_X        320
`define OBJ1_Y        416
`define OBJ_W         32
`define OBJ_H         32

`endif

// ==== hw/spritePkg.sv ====
// coordinate, box and table index types
// jump phase encoding
`include "spriteMotion_cfg.svh"

package spritePkg;

	// signed display coordinate
	typedef logic signed [`COORD_W:0] coord_t;

	// 48-bit bounding box
	typedef struct packed
	{
		coord_t left;
		coord_t right;
		coord_t top;
		coord_t bottom;
	} box_t;

	// one entry per object
	typedef logic [$clog2(`NUM_OBJ)-1:0] objIdx_t;

	//------------------------------------------------------------
	// vertical motion phase
	//------------------------------------------------------------
	typedef enum logic [1:0]
	{
		JUMP_IDLE,	// grounded or free walking
		JUMP_RISE,	// moving up as the speed slows
		JUMP_FALL	// moving down until ground
	} jumpPhase_e;

endpackage

// ==== hw/moverIf.sv ====
// per-frame post from one position generator to the table arbiter
interface moverIf
	import spritePkg::*;
();

	logic updStb;		// one cycle per frame
	box_t box;			// stable until next strobe
	logic wallLeft;		// box touches left edge
	logic wallRight;	// box touches right edge

	modport mover
	(
		output updStb, box, wallLeft, wallRight
	);

	modport arbiter
	(
		input updStb, box, wallLeft, wallRight
	);

endinterface

// ==== hw/objectPosGen.sv ====
// per-object position generator
// walk and dash on x with wall clamp, jump rise and fall on y with ground clamp
`include "spriteMotion_cfg.svh"

module objectPosGen
	import spritePkg::*;
#(
	parameter int initX = 0,
	parameter int initY = 0,
	parameter int sizeX = 16,
	parameter int sizeY = 16
)(
	input  logic                         iClk,
	input  logic                         rstN,
	input  logic                         frameEnd,
	input  coord_t                       hDisplay,	// right wall
	input  coord_t                       vDisplay,	// ground line
	input  logic signed [`BASIC_GAIN_W:0] basicGain,
	input  logic signed [`DASH_GAIN_W:0]  dashGain,
	input  coord_t                       jumpPeak,	// rise height budget
	input  coord_t                       jumpGain,	// launch speed
	input  logic signed [`JUMP_VEL_W:0]   jumpVelMax,
	input  logic signed [`JUMP_VEL_W:0]   jumpVelMin,
	input  logic [`JUMP_PER_W-1:0]        jumpPeriod,
	input  logic                         leftKey,
	input  logic                         rightKey,
	input  logic                         upKey,
	input  logic                         downKey,
	input  logic                         dashKey,
	input  logic                         jumpKey,
	moverIf.mover                        post
);

	localparam coord_t boxW = coord_t'(sizeX);
	localparam coord_t boxH = coord_t'(sizeY);
	localparam box_t startBox = '{
		left:   coord_t'(initX),
		right:  coord_t'(initX + sizeX),
		top:    coord_t'(initY),
		bottom: coord_t'(initY + sizeY)
	};

	box_t                  boxQ, boxD;
	jumpPhase_e            phaseQ, phaseD;
	coord_t                velQ, velD;			// current vertical speed
	coord_t                remainQ, remainD;	// height left to rise
	logic [`JUMP_PER_W-1:0] frmCntQ, frmCntD;	// frames since last speed step
	logic                  updStbQ;

	coord_t walkStep;
	coord_t climbStep;
	coord_t xNxtLeft, xNxtRight;
	coord_t yNxtTop, yNxtBottom;
	coord_t remainNxt;
	logic   moveL, moveR;
	logic   grounded;
	logic   periodHit;

	//------------------------------------------------------------
	// next box and jump state, applied only on frameEnd
	//------------------------------------------------------------
	always_comb
	begin
		moveL = leftKey & ~rightKey;	// both keys cancel
		moveR = rightKey & ~leftKey;
		walkStep = dashKey ? coord_t'(dashGain) : coord_t'(basicGain);
		climbStep = coord_t'(basicGain);

		xNxtLeft = boxQ.left;
		xNxtRight = boxQ.right;
		if (moveR)
		begin
			xNxtLeft = boxQ.left + walkStep;
			xNxtRight = boxQ.right + walkStep;
		end
		else if (moveL)
		begin
			xNxtLeft = boxQ.left - walkStep;
			xNxtRight = boxQ.right - walkStep;
		end

		boxD = boxQ;
		// wall clamp keeps the width
		if (xNxtLeft < 0)
		begin
			boxD.left = '0;
			boxD.right = boxW;
		end
		else if (xNxtRight > hDisplay)
		begin
			boxD.left = hDisplay - boxW;
			boxD.right = hDisplay;
		end
		else
		begin
			boxD.left = xNxtLeft;
			boxD.right = xNxtRight;
		end

		// speed step every jumpPeriod frames
		grounded = (boxQ.bottom == vDisplay);
		periodHit = ({1'b0, frmCntQ} + 1'b1) >= {1'b0, jumpPeriod};
		frmCntD = periodHit ? '0 : frmCntQ + 1'b1;

		phaseD = phaseQ;
		velD = velQ;
		remainD = remainQ;
		remainNxt = remainQ - velQ;
		yNxtTop = boxQ.top + velQ;			// fall candidate
		yNxtBottom = boxQ.bottom + velQ;

		case (phaseQ)
			JUMP_IDLE:
			begin
				frmCntD = '0;
				if (jumpKey && grounded)
				begin
					phaseD = JUMP_RISE;
					velD = jumpGain;
					remainD = jumpPeak;
				end
				else if (upKey && !downKey)
				begin
					boxD.top = boxQ.top - climbStep;	// free move without clamp
					boxD.bottom = boxQ.bottom - climbStep;
				end
				else if (downKey && !upKey)
				begin
					boxD.top = boxQ.top + climbStep;
					boxD.bottom = boxQ.bottom + climbStep;
				end
			end
			JUMP_RISE:
			begin
				boxD.top = boxQ.top - velQ;
				boxD.bottom = boxQ.bottom - velQ;
				remainD = remainNxt;
				if (periodHit && (velQ > coord_t'(jumpVelMin)))
					velD = velQ - 1'b1;		// slow down near the peak
				// peak reached or key let go
				if ((remainNxt < 0) || !jumpKey)
					phaseD = JUMP_FALL;
			end
			JUMP_FALL:
			begin
				if (periodHit && (velQ < coord_t'(jumpVelMax)))
					velD = velQ + 1'b1;		// speed up while falling
				if (yNxtBottom >= vDisplay)
				begin
					boxD.top = vDisplay - boxH;	// land on ground line
					boxD.bottom = vDisplay;
					phaseD = JUMP_IDLE;
				end
				else
				begin
					boxD.top = yNxtTop;
					boxD.bottom = yNxtBottom;
				end
			end
			default:
				phaseD = JUMP_IDLE;
		endcase
	end

	//------------------------------------------------------------
	// state registers
	//------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			boxQ <= startBox;
			phaseQ <= JUMP_IDLE;
			updStbQ <= 1'b0;
		end
		else
		begin
			updStbQ <= frameEnd;	// post goes out with the new box
			if (frameEnd)
			begin
				boxQ <= boxD;
				phaseQ <= phaseD;
			end
		end
	end

	// jump speed, rise budget and speed step counter
	always_ff @(posedge iClk)
	begin
		if (frameEnd)
		begin
			velQ <= velD;
			remainQ <= remainD;
			frmCntQ <= frmCntD;
		end
	end

	assign post.updStb = updStbQ;
	assign post.box = boxQ;
	assign post.wallLeft = (boxQ.left == '0);
	assign post.wallRight = (boxQ.right == hDisplay);

endmodule

// ==== hw/tableArbiter.sv ====
// round-robin arbiter from the generator posts to single table writes
`include "spriteMotion_cfg.svh"

module tableArbiter
	import spritePkg::*;
(
	input  logic    iClk,
	input  logic    rstN,
	moverIf.arbiter req [`NUM_OBJ],
	output logic    wrStb,
	output objIdx_t wrIdx,
	output box_t    wrBox,
	output logic    wrWallLeft,
	output logic    wrWallRight
);

	logic [`NUM_OBJ-1:0] postStb, postWallL, postWallR;
	box_t                postBox [`NUM_OBJ];
	logic [`NUM_OBJ-1:0] pendQ;					// post waiting for a grant
	box_t                latBox [`NUM_OBJ];		// latched post
	logic [`NUM_OBJ-1:0] latWallL, latWallR;
	logic [`NUM_OBJ-1:0] reqV, gnt;
	objIdx_t             turnQ, gntIdx;
	logic                anyGnt;
	logic                contested;

	// flatten the interface array
	for (genvar g = 0; g < `NUM_OBJ; g++)
	begin : gPost
		assign postStb[g] = req[g].updStb;
		assign postBox[g] = req[g].box;
		assign postWallL[g] = req[g].wallLeft;
		assign postWallR[g] = req[g].wallRight;
	end

	assign reqV = postStb | pendQ;
	assign contested = ($countones(reqV) > 1);

	//------------------------------------------------------------
	// grant search starting at the turn pointer
	//------------------------------------------------------------
	always_comb
	begin
		int cand;
		gnt = '0;
		gntIdx = turnQ;
		anyGnt = 1'b0;
		for (int k = 0; k < `NUM_OBJ; k++)
		begin
			cand = (int'(turnQ) + k) % `NUM_OBJ;
			if (!anyGnt && reqV[cand])
			begin
				anyGnt = 1'b1;
				gnt[cand] = 1'b1;
				gntIdx = objIdx_t'(cand);
			end
		end
	end

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrStb <= 1'b0;
			pendQ <= '0;
			turnQ <= '0;
		end
		else
		begin
			wrStb <= anyGnt;
			pendQ <= reqV & ~gnt;	// losers wait one more cycle
			// pointer moves on a clash only, so the lead swaps each frame
			if (anyGnt && contested)
				turnQ <= objIdx_t'((int'(gntIdx) + 1) % `NUM_OBJ);
		end
	end

	// payload path
	always_ff @(posedge iClk)
	begin
		for (int i = 0; i < `NUM_OBJ; i++)
		begin
			if (postStb[i] && !gnt[i])
			begin
				latBox[i] <= postBox[i];
				latWallL[i] <= postWallL[i];
				latWallR[i] <= postWallR[i];
			end
		end
		if (anyGnt)
		begin
			wrIdx <= gntIdx;
			wrBox <= pendQ[gntIdx] ? latBox[gntIdx] : postBox[gntIdx];
			wrWallLeft <= pendQ[gntIdx] ? latWallL[gntIdx] : postWallL[gntIdx];
			wrWallRight <= pendQ[gntIdx] ? latWallR[gntIdx] : postWallR[gntIdx];
		end
	end

endmodule

// ==== hw/objectTable.sv ====
// object table of boxes and wall flags
// one write port, registered read port
`include "spriteMotion_cfg.svh"

module objectTable
	import spritePkg::*;
(
	input  logic    iClk,
	input  logic    rstN,
	input  logic    wrStb,
	input  objIdx_t wrIdx,
	input  box_t    wrBox,
	input  logic    wrWallLeft,
	input  logic    wrWallRight,
	input  objIdx_t rdIdx,
	output box_t    rdBox,
	output logic    rdWallLeft,
	output logic    rdWallRight
);

	localparam box_t startBox [`NUM_OBJ] = '{
		'{left: coord_t'(`OBJ0_X), right: coord_t'(`OBJ0_X + `OBJ_W),
		  top: coord_t'(`OBJ0_Y), bottom: coord_t'(`OBJ0_Y + `OBJ_H)},
		'{left: coord_t'(`OBJ1_X), right: coord_t'(`OBJ1_X + `OBJ_W),
		  top: coord_t'(`OBJ1_Y), bottom: coord_t'(`OBJ1_Y + `OBJ_H)}
	};

	box_t                boxTbl [`NUM_OBJ];
	logic [`NUM_OBJ-1:0] wallLTbl, wallRTbl;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `NUM_OBJ; i++)
				boxTbl[i] <= startBox[i];	// objects start off both walls
			wallLTbl <= '0;
			wallRTbl <= '0;
		end
		else if (wrStb)
		begin
			boxTbl[wrIdx] <= wrBox;
			wallLTbl[wrIdx] <= wrWallLeft;
			wallRTbl[wrIdx] <= wrWallRight;
		end
	end

	// read data one cycle after rdIdx
	always_ff @(posedge iClk)
	begin
		rdBox <= boxTbl[rdIdx];
		rdWallLeft <= wallLTbl[rdIdx];
		rdWallRight <= wallRTbl[rdIdx];
	end

endmodule

// ==== hw/spriteMotion.sv ====
// top level of the sprite motion subsystem
// two position generators, post arbiter and object table
`include "spriteMotion_cfg.svh"

module spriteMotion
	import spritePkg::*;
(
	input  logic                         iClk,
	input  logic                         rstN,
	input  logic                         frameEnd,
	input  coord_t                       hDisplay,
	input  coord_t                       vDisplay,
	input  logic signed [`BASIC_GAIN_W:0] basicGain,
	input  logic signed [`DASH_GAIN_W:0]  dashGain,
	input  coord_t                       jumpPeak,
	input  coord_t                       jumpGain,
	input  logic signed [`JUMP_VEL_W:0]   jumpVelMax,
	input  logic signed [`JUMP_VEL_W:0]   jumpVelMin,
	input  logic [`JUMP_PER_W-1:0]        jumpPeriod,
	input  logic [`NUM_OBJ-1:0]           leftKey,	// one bit per object
	input  logic [`NUM_OBJ-1:0]           rightKey,
	input  logic [`NUM_OBJ-1:0]           upKey,
	input  logic [`NUM_OBJ-1:0]           downKey,
	input  logic [`NUM_OBJ-1:0]           dashKey,
	input  logic [`NUM_OBJ-1:0]           jumpKey,
	input  objIdx_t                      rdIdx,
	output box_t                         rdBox,
	output logic                         rdWallLeft,
	output logic                         rdWallRight,
	output logic                         tblWrStb,	// arbitrated write stream
	output objIdx_t                      tblWrIdx,
	output box_t                         tblWrBox
);

	logic wrWallLeft;
	logic wrWallRight;

	moverIf post [`NUM_OBJ] ();

	//------------------------------------------------------------
	// position generators
	//------------------------------------------------------------
	objectPosGen #(
		.initX(`OBJ0_X), .initY(`OBJ0_Y), .sizeX(`OBJ_W), .sizeY(`OBJ_H)
	) posGen0 (
		.iClk(iClk), .rstN(rstN), .frameEnd(frameEnd),
		.hDisplay(hDisplay), .vDisplay(vDisplay),
		.basicGain(basicGain), .dashGain(dashGain),
		.jumpPeak(jumpPeak), .jumpGain(jumpGain),
		.jumpVelMax(jumpVelMax), .jumpVelMin(jumpVelMin), .jumpPeriod(jumpPeriod),
		.leftKey(leftKey[0]), .rightKey(rightKey[0]), .upKey(upKey[0]),
		.downKey(downKey[0]), .dashKey(dashKey[0]), .jumpKey(jumpKey[0]),
		.post(post[0])
	);

	objectPosGen #(
		.initX(`OBJ1_X), .initY(`OBJ1_Y), .sizeX(`OBJ_W), .sizeY(`OBJ_H)
	) posGen1 (
		.iClk(iClk), .rstN(rstN), .frameEnd(frameEnd),
		.hDisplay(hDisplay), .vDisplay(vDisplay),
		.basicGain(basicGain), .dashGain(dashGain),
		.jumpPeak(jumpPeak), .jumpGain(jumpGain),
		.jumpVelMax(jumpVelMax), .jumpVelMin(jumpVelMin), .jumpPeriod(jumpPeriod),
		.leftKey(leftKey[1]), .rightKey(rightKey[1]), .upKey(upKey[1]),
		.downKey(downKey[1]), .dashKey(dashKey[1]), .jumpKey(jumpKey[1]),
		.post(post[1])
	);

	//------------------------------------------------------------
	// arbiter and table
	//------------------------------------------------------------
	tableArbiter arb0 (
		.iClk(iClk), .rstN(rstN), .req(post),
		.wrStb(tblWrStb), .wrIdx(tblWrIdx), .wrBox(tblWrBox),
		.wrWallLeft(wrWallLeft), .wrWallRight(wrWallRight)
	);

	objectTable tbl0 (
		.iClk(iClk), .rstN(rstN),
		.wrStb(tblWrStb), .wrIdx(tblWrIdx), .wrBox(tblWrBox),
		.wrWallLeft(wrWallLeft), .wrWallRight(wrWallRight),
		.rdIdx(rdIdx), .rdBox(rdBox),
		.rdWallLeft(rdWallLeft), .rdWallRight(rdWallRight)
	);

endmodule

// ==== bench/spriteMotion_props.sv ====
// arbiter checks bound into every tableArbiter
// write spacing per entry, post to write latency, granted index
`include "spriteMotion_cfg.svh"

module arbiterChecks
	import spritePkg::*;
(
	input logic                iClk,
	input logic                rstN,
	input logic [`NUM_OBJ-1:0] postStb,
	input logic [`NUM_OBJ-1:0] pendQ,
	input logic                wrStb,
	input objIdx_t             wrIdx
);
	timeunit 1ns;
	timeprecision 1ps;

	int violationCnt = 0;	// read by the testbench top

	logic [`NUM_OBJ-1:0] reqPrev;	// requests seen at the grant edge

	always_ff @(posedge iClk)
		reqPrev <= postStb | pendQ;

	// posts of one frame go to different entries
	noRepeatWrite: assert property (@(posedge iClk) disable iff (!rstN)
		(wrStb && $past(wrStb)) |-> (wrIdx != $past(wrIdx)))
	else
	begin
		violationCnt++;
		$error("entry %0d written on two cycles running", wrIdx);
	end

	//------------------------------------------------------------
	// winner writes one cycle after the post, loser one later
	//------------------------------------------------------------
	for (genvar g = 0; g < `NUM_OBJ; g++)
	begin : gLatency
		postWritten: assert property (@(posedge iClk) disable iff (!rstN)
			$past(postStb[g], 2) |-> ((wrStb && wrIdx == objIdx_t'(g))
				|| ($past(wrStb) && $past(wrIdx) == objIdx_t'(g))))
		else
		begin
			violationCnt++;
			$error("post of object %0d not written within 2 cycles", g);
		end
	end

	// written index belongs to a waiting requester
	idxRequested: assert property (@(posedge iClk) disable iff (!rstN)
		wrStb |-> reqPrev[wrIdx])
	else
	begin
		violationCnt++;
		$error("write index %0d had no pending post", wrIdx);
	end

endmodule

bind tableArbiter arbiterChecks checks0 (
	.iClk(iClk), .rstN(rstN), .postStb(postStb), .pendQ(pendQ),
	.wrStb(wrStb), .wrIdx(wrIdx)
);

// ==== bench/spriteMotionTb.sv ====
// sprite motion testbench with clock, reset and keyed frame stimulus
// reference model of both objects, write stream and table readback checks
`include "spriteMotion_cfg.svh"

module spriteMotionTb
	import spritePkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// display and motion settings
	localparam coord_t displayW = 640;
	localparam coord_t groundY = 448;	// start boxes sit on it
	localparam coord_t walkGain = 3;
	localparam coord_t dashStep = 9;
	localparam coord_t peakHeight = 60;
	localparam coord_t launchSpeed = 8;
	localparam coord_t speedMax = 10;
	localparam coord_t speedMin = 2;
	localparam logic [`JUMP_PER_W-1:0] speedPeriod = 2;
	localparam coord_t boxW = `OBJ_W;
	localparam coord_t boxH = `OBJ_H;

	// key vector bits
	localparam logic [5:0] leftBit = 6'b000001;
	localparam logic [5:0] rightBit = 6'b000010;
	localparam logic [5:0] dashBit = 6'b010000;
	localparam logic [5:0] jumpBit = 6'b100000;
	localparam logic [5:0] walkMask = leftBit | rightBit | dashBit;

	localparam int walkFrames = 16;
	localparam int wallFrames = 40;
	localparam int jumpFrames = 30;
	localparam int releaseFrames = 18;
	localparam int mixFrames = 24;
	localparam int totalFrames = walkFrames + wallFrames + jumpFrames + releaseFrames + mixFrames;
	localparam int timeoutCycles = totalFrames * 8 + 100;

	typedef struct packed
	{
		box_t                   box;
		jumpPhase_e             phase;
		coord_t                 vel;	// vertical speed
		coord_t                 remain;	// rise height left
		logic [`JUMP_PER_W-1:0] cnt;	// frames since speed step
	} modelState_t;

	logic                         iClk;
	logic                         rstN;
	logic                         frameEnd;
	coord_t                       hDisplay, vDisplay;
	logic signed [`BASIC_GAIN_W:0] basicGain;
	logic signed [`DASH_GAIN_W:0]  dashGain;
	coord_t                       jumpPeak, jumpGain;
	logic signed [`JUMP_VEL_W:0]   jumpVelMax, jumpVelMin;
	logic [`JUMP_PER_W-1:0]        jumpPeriod;
	logic [`NUM_OBJ-1:0]           leftKey, rightKey, upKey, downKey, dashKey, jumpKey;
	objIdx_t                      rdIdx;
	box_t                         rdBox;
	logic                         rdWallLeft, rdWallRight;
	logic                         tblWrStb;
	objIdx_t                      tblWrIdx;
	box_t                         tblWrBox;

	modelState_t         model [`NUM_OBJ];
	box_t                expBox [`NUM_OBJ];	// expected table contents
	logic [`NUM_OBJ-1:0] expWallL, expWallR;
	objIdx_t             expFirst;			// first grant of this frame
	int                  framesSent = 0;
	int                  writesSeen = 0;
	int                  readsChecked = 0;
	int                  cycleCnt = 0;

	spriteMotion dut0 (.*);

	initial
	begin
		iClk = 1'b0;
		forever #50 iClk = ~iClk;
	end

	task automatic abortRun(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic box_t cornerBox(input int x, input int y);
		box_t b;
		b.left = coord_t'(x);
		b.right = coord_t'(x + `OBJ_W);
		b.top = coord_t'(y);
		b.bottom = coord_t'(y + `OBJ_H);
		return b;
	endfunction

	//------------------------------------------------------------
	// reference model, one frame of one object
	//------------------------------------------------------------
	function automatic modelState_t stepObject(input modelState_t s, input logic [5:0] k);
		modelState_t n;
		coord_t step;
		coord_t nl;
		coord_t nr;
		logic hit;
		n = s;
		step = k[4] ? dashStep : walkGain;
		nl = s.box.left;
		nr = s.box.right;
		if (k[0] && !k[1])
		begin
			nl = nl - step;
			nr = nr - step;
		end
		else if (k[1] && !k[0])
		begin
			nl = nl + step;
			nr = nr + step;
		end
		n.box.left = (nl < 0) ? coord_t'(0) : (nr > displayW) ? displayW - boxW : nl;
		n.box.right = (nl < 0) ? boxW : (nr > displayW) ? displayW : nr;
		hit = (int'(s.cnt) + 1) >= int'(speedPeriod);	// speed step frame
		n.cnt = hit ? '0 : s.cnt + 1'b1;
		case (s.phase)
			JUMP_IDLE:
			begin
				n.cnt = '0;
				if (k[5] && s.box.bottom == groundY)
				begin
					n.phase = JUMP_RISE;
					n.vel = launchSpeed;
					n.remain = peakHeight;
				end
				else if (k[2] != k[3])
				begin
					n.box.top = k[2] ? s.box.top - walkGain : s.box.top + walkGain;
					n.box.bottom = n.box.top + boxH;
				end
			end
			JUMP_RISE:
			begin
				n.box.top = s.box.top - s.vel;
				n.box.bottom = s.box.bottom - s.vel;
				n.remain = s.remain - s.vel;
				if (hit && s.vel > speedMin)
					n.vel = s.vel - coord_t'(1);
				if (n.remain < 0 || !k[5])
					n.phase = JUMP_FALL;	// peak or early release
			end
			default:
			begin
				if (hit && s.vel < speedMax)
					n.vel = s.vel + coord_t'(1);
				n.box.top = s.box.top + s.vel;
				n.box.bottom = s.box.bottom + s.vel;
				if (n.box.bottom >= groundY)
				begin
					n.box.top = groundY - boxH;	// landed
					n.box.bottom = groundY;
					n.phase = JUMP_IDLE;
				end
			end
		endcase
		return n;
	endfunction

	task automatic loadExpected(input int i);
		expBox[i] = model[i].box;
		expWallL[i] = (model[i].box.left == 0);
		expWallR[i] = (model[i].box.right == displayW);
	endtask

	// keys and frameEnd go out together, then 7 idle cycles
	task automatic runFrame(input logic [`NUM_OBJ-1:0][5:0] kv);
		@(posedge iClk);
		frameEnd <= 1'b1;
		for (int i = 0; i < `NUM_OBJ; i++)
		begin
			leftKey[i] <= kv[i][0];
			rightKey[i] <= kv[i][1];
			upKey[i] <= kv[i][2];
			downKey[i] <= kv[i][3];
			dashKey[i] <= kv[i][4];
			jumpKey[i] <= kv[i][5];
			model[i] = stepObject(model[i], kv[i]);
			loadExpected(i);
		end
		expFirst = objIdx_t'(framesSent % `NUM_OBJ);	// lead swaps each frame
		framesSent++;
		@(posedge iClk);
		frameEnd <= 1'b0;
		repeat (6) @(posedge iClk);
	endtask

	initial
	begin : stimulus
		void'($urandom(32'hd168_8c14));
		rstN = 1'b0;
		frameEnd = 1'b0;
		hDisplay = displayW;
		vDisplay = groundY;
		basicGain = 3;
		dashGain = 9;
		jumpPeak = peakHeight;
		jumpGain = launchSpeed;
		jumpVelMax = 10;
		jumpVelMin = 2;
		jumpPeriod = speedPeriod;
		leftKey = '0;
		rightKey = '0;
		upKey = '0;
		downKey = '0;
		dashKey = '0;
		jumpKey = '0;
		model[0] = '{box: cornerBox(`OBJ0_X, `OBJ0_Y), phase: JUMP_IDLE, default: '0};
		model[1] = '{box: cornerBox(`OBJ1_X, `OBJ1_Y), phase: JUMP_IDLE, default: '0};
		loadExpected(0);
		loadExpected(1);
		repeat (4) @(posedge iClk);
		rstN <= 1'b1;
		repeat (7) @(posedge iClk);	// start boxes read back first

		for (int f = 0; f < walkFrames; f++)
			runFrame({6'($urandom) & walkMask, 6'($urandom) & walkMask});
		for (int f = 0; f < wallFrames; f++)
			runFrame({rightBit | dashBit, leftBit | dashBit});	// obj0 left, obj1 right
		// up and down stay random while the jump key is held
		for (int f = 0; f < jumpFrames; f++)
			runFrame({6'($urandom) | jumpBit, 6'($urandom) | jumpBit});
		for (int f = 0; f < releaseFrames; f++)
			runFrame({((f % 6) < 2 ? jumpBit : 6'b0) | (6'($urandom) & walkMask),
				((f % 6) < 2 ? jumpBit : 6'b0) | (6'($urandom) & walkMask)});
		for (int f = 0; f < mixFrames; f++)
			runFrame({6'($urandom), 6'($urandom)});

		repeat (4) @(posedge iClk);
		if (writesSeen == 2 * totalFrames && readsChecked == 2 * totalFrames + 2)
		begin
			$display(">>> PASS");
			$finish;
		end
		else
			abortRun($sformatf("saw %0d writes and %0d readbacks, expected %0d and %0d",
				writesSeen, readsChecked, 2 * totalFrames, 2 * totalFrames + 2));
	end

	task automatic checkReadback(input objIdx_t idx);
		assert (rdBox == expBox[idx])
		else
			abortRun($sformatf("ERR rdBox[%0d] got %h expected %h", idx, rdBox, expBox[idx]));
		assert (rdWallLeft == expWallL[idx])
		else
			abortRun($sformatf("ERR rdWallLeft[%0d] got %h expected %h",
				idx, rdWallLeft, expWallL[idx]));
		assert (rdWallRight == expWallR[idx])
		else
			abortRun($sformatf("ERR rdWallRight[%0d] got %h expected %h",
				idx, rdWallRight, expWallR[idx]));
		readsChecked++;
	endtask

	//------------------------------------------------------------
	// comparator on the write stream and the read port
	//------------------------------------------------------------
	initial
	begin : compare
		int sampleCyc;
		int framesSampled;
		logic [`NUM_OBJ-1:0] seenMask;
		logic chk1Valid, chk2Valid;
		objIdx_t chk1Idx, chk2Idx;
		sampleCyc = 0;
		framesSampled = 0;
		seenMask = '0;
		chk1Valid = 1'b0;
		chk2Valid = 1'b0;
		chk1Idx = '0;
		chk2Idx = '0;
		rdIdx = '0;
		wait (rstN === 1'b1);
		@(posedge iClk);
		rdIdx <= objIdx_t'(0);
		@(posedge iClk);
		rdIdx <= objIdx_t'(1);
		for (int i = 0; i < `NUM_OBJ; i++)
		begin
			@(posedge iClk);
			assert (!tblWrStb) else abortRun("table write seen before the first frameEnd");
			checkReadback(objIdx_t'(i));
		end
		forever
		begin
			@(posedge iClk);
			if (frameEnd)
			begin
				sampleCyc = cycleCnt;	// edge where the DUT takes the frame
				framesSampled++;
				seenMask = '0;
			end
			if (chk2Valid)
				checkReadback(chk2Idx);
			chk2Valid = chk1Valid;
			chk2Idx = chk1Idx;
			chk1Valid = 1'b0;
			if (tblWrStb)
			begin
				assert (framesSampled > 0) else abortRun("table write seen before any frameEnd");
				assert (cycleCnt - sampleCyc <= 3)
				else
					abortRun("table write came more than 3 edges after frameEnd");
				assert (!seenMask[tblWrIdx]) else abortRun("one object written twice in a frame");
				if (seenMask == '0)
					assert (tblWrIdx == expFirst)
					else
						abortRun($sformatf("ERR tblWrIdx got %h expected %h", tblWrIdx, expFirst));
				assert (tblWrBox == expBox[tblWrIdx])
				else
					abortRun($sformatf("ERR tblWrBox[%0d] got %h expected %h",
						tblWrIdx, tblWrBox, expBox[tblWrIdx]));
				seenMask[tblWrIdx] = 1'b1;
				writesSeen++;
				rdIdx <= tblWrIdx;	// read the entry back
				chk1Valid = 1'b1;
				chk1Idx = tblWrIdx;
			end
			if (framesSampled > 0 && cycleCnt - sampleCyc == 4)
				assert (seenMask == '1) else abortRun("an object was not written after frameEnd");
		end
	end

	// cycle limit and bound property failures
	always @(posedge iClk)
	begin
		cycleCnt <= cycleCnt + 1;
		assert (cycleCnt < timeoutCycles)
		else
			abortRun($sformatf("run did not finish within %0d cycles", timeoutCycles));
		assert (dut0.arb0.checks0.violationCnt == 0)
		else
			abortRun("a bound arbiter property failed");
	end

endmodule

// ==== spriteMotion.f ====
+incdir+hw
hw/spritePkg.sv
hw/moverIf.sv
hw/objectPosGen.sv
hw/tableArbiter.sv
hw/objectTable.sv
hw/spriteMotion.sv
bench/spriteMotion_props.sv
bench/spriteMotionTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the sprite motion testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert -Wno-fatal \
	--top-module spriteMotionTb -f spriteMotion.f \
	-o spriteMotionSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/spriteMotionSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qx '>>> PASS' "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1
